/* usb_consts.svh */
`ifndef USB_CONSTS_SVH
`define USB_CONSTS_SVH

// Token PIDs
`define USBPID_OUT     4'b0001
`define USBPID_IN      4'b1001
`define USBPID_PING    4'b0100

// Data PIDs, bit 3 carries the toggle
`define USBPID_DATA0   4'b0011
`define USBPID_DATA1   4'b1011

// Handshake PIDs
`define USBPID_ACK     4'b0010
`define USBPID_NAK     4'b1010
`define USBPID_STALL   4'b1110

// Bulk endpoint numbers
`define USB_EP_OUT     4'd1
`define USB_EP_IN      4'd2

// Packet and buffer sizes in bytes
`define USB_MAX_PKT    64
`define USB_OUT_DEPTH  128
`define USB_IN_DEPTH   128

// Turnaround limit, 816 bit times at 8 bits per clock
`define USB_TURNAROUND 102

`endif

/* usb_pkg.sv */
package usb_pkg;

  // Packet identifier as seen on the decoder and encoder side
  typedef logic [3:0] pid_t;

  // Device address carried in a token
  typedef logic [6:0] usb_addr_t;

  // Endpoint number carried in a token
  typedef logic [3:0] endp_t;

  // Payload byte
  typedef logic [7:0] byte_t;

  // Transaction controller states
  typedef enum logic [2:0] {
    // Unconfigured, endpoint tokens get STALL
    HALT,
    IDLE,
    // Waiting for DATAx after an OUT token
    DPID,
    RECV,
    // Packet is received but thrown away
    DROP,
    // Handshake pending at the encoder
    RESP,
    SEND,
    // Waiting for the host's ACK
    WAIT
  } xact_state_t;

endpackage

/* usb_transaction_ctrl.sv */
`timescale 1ns/100ps
`include "usb_consts.svh"

module usb_transaction_ctrl import usb_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  usb_addr_t dev_addr_i,
  input  logic      set_conf_i,
  input  logic      clr_conf_i,
  input  logic      tok_recv_i,
  input  pid_t      usb_pid_i,
  input  usb_addr_t tok_addr_i,
  input  endp_t     tok_endp_i,
  input  logic      usb_recv_i,
  input  logic      eop_recv_i,
  input  logic      crc_error_i,
  input  logic      hsk_recv_i,
  input  logic      hsk_sent_i,
  input  logic      usb_sent_i,
  input  logic      out_room_i,
  input  logic      in_ready_i,
  output logic      hsk_send_o,
  output logic      data_send_o,
  output pid_t      usb_pid_o,
  output logic      out_accept_o,
  output logic      out_commit_o,
  output logic      out_discard_o,
  output logic      in_send_o,
  output logic      in_release_o,
  output logic      in_rewind_o
);

  localparam int TMR_W = $clog2(`USB_TURNAROUND);
  localparam logic [TMR_W-1:0] TMR_MAX = TMR_W'(`USB_TURNAROUND - 1);

  xact_state_t state_q, state_d;
  pid_t pid_d;
  logic hsk_d, data_d;
  logic commit_d, discard_d, release_d, rewind_d;
  logic conf_q;
  logic out_tgl_q, in_tgl_q;
  logic [TMR_W-1:0] timer_q;
  logic timing_w, timeout_w;
  logic tok_match_w, out_tok_w, ping_tok_w, in_tok_w;
  logic data1_w;
  xact_state_t idle_w;

  // Only tokens for this device and its two bulk endpoints are seen
  assign tok_match_w = tok_recv_i && tok_addr_i == dev_addr_i;
  assign out_tok_w   = usb_pid_i == `USBPID_OUT && tok_endp_i == `USB_EP_OUT;
  assign ping_tok_w  = usb_pid_i == `USBPID_PING && tok_endp_i == `USB_EP_OUT;
  assign in_tok_w    = usb_pid_i == `USBPID_IN && tok_endp_i == `USB_EP_IN;
  assign data1_w     = usb_pid_i == `USBPID_DATA1;

  // Where a finished transaction returns to
  assign idle_w = conf_q ? IDLE : HALT;

  assign timing_w  = state_q == DPID || state_q == WAIT;
  assign timeout_w = timing_w && timer_q == TMR_MAX;

  always_comb begin
    state_d   = state_q;
    pid_d     = usb_pid_o;
    hsk_d     = hsk_send_o;
    data_d    = data_send_o;
    commit_d  = 1'b0;
    discard_d = 1'b0;
    release_d = 1'b0;
    rewind_d  = 1'b0;
    case (state_q)
      HALT: begin
        if (conf_q) begin
          state_d = IDLE;
        end else if (tok_match_w && (out_tok_w || ping_tok_w || in_tok_w)) begin
          state_d = RESP;
          pid_d   = `USBPID_STALL;
          hsk_d   = 1'b1;
        end
      end
      IDLE: begin
        if (!conf_q) begin
          state_d = HALT;
        end else if (tok_match_w && out_tok_w) begin
          state_d = DPID;
        end else if (tok_match_w && ping_tok_w) begin
          state_d = RESP;
          pid_d   = out_room_i ? `USBPID_ACK : `USBPID_NAK;
          hsk_d   = 1'b1;
        end else if (tok_match_w && in_tok_w && in_ready_i) begin
          state_d = SEND;
          pid_d   = in_tgl_q ? `USBPID_DATA1 : `USBPID_DATA0;
          data_d  = 1'b1;
        end else if (tok_match_w && in_tok_w) begin
          state_d = RESP;
          pid_d   = `USBPID_NAK;
          hsk_d   = 1'b1;
        end
      end
      DPID: begin
        if (usb_recv_i) begin
          // A repeated toggle is acknowledged but never stored
          if (data1_w != out_tgl_q) begin
            state_d = DROP;
            pid_d   = `USBPID_ACK;
          end else if (!out_room_i) begin
            state_d = DROP;
            pid_d   = `USBPID_NAK;
          end else begin
            state_d = RECV;
          end
        end else if (timeout_w) begin
          state_d = idle_w;
        end
      end
      RECV: begin
        // Bad CRC, stay silent and let the host retry
        if (crc_error_i) begin
          state_d   = idle_w;
          discard_d = 1'b1;
        end else if (eop_recv_i) begin
          state_d  = RESP;
          pid_d    = `USBPID_ACK;
          hsk_d    = 1'b1;
          commit_d = 1'b1;
        end
      end
      DROP: begin
        if (crc_error_i) begin
          state_d = idle_w;
        end else if (eop_recv_i) begin
          state_d = RESP;
          hsk_d   = 1'b1;
        end
      end
      RESP: begin
        if (hsk_sent_i) begin
          state_d = idle_w;
          hsk_d   = 1'b0;
        end
      end
      SEND: begin
        if (usb_sent_i) begin
          state_d = WAIT;
          data_d  = 1'b0;
        end
      end
      WAIT: begin
        if (hsk_recv_i) begin
          state_d   = idle_w;
          release_d = 1'b1;
        end else if (timeout_w) begin
          state_d  = idle_w;
          rewind_d = 1'b1;
        end
      end
      default: begin
        state_d = HALT;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q       <= HALT;
      hsk_send_o    <= 1'b0;
      data_send_o   <= 1'b0;
      out_commit_o  <= 1'b0;
      out_discard_o <= 1'b0;
      in_release_o  <= 1'b0;
      in_rewind_o   <= 1'b0;
    end else begin
      state_q       <= state_d;
      hsk_send_o    <= hsk_d;
      data_send_o   <= data_d;
      out_commit_o  <= commit_d;
      out_discard_o <= discard_d;
      in_release_o  <= release_d;
      in_rewind_o   <= rewind_d;
    end
  end

  // PID is only looked at while one of the send strobes is up
  always_ff @(posedge clock) begin
    usb_pid_o <= pid_d;
  end

  // Configuration and data toggles
  always_ff @(posedge clock) begin
    if (reset || clr_conf_i) begin
      conf_q <= 1'b0;
    end else if (set_conf_i) begin
      conf_q <= 1'b1;
    end
    if (reset || set_conf_i) begin
      out_tgl_q <= 1'b0;
      in_tgl_q  <= 1'b0;
    end else begin
      if (commit_d) begin
        out_tgl_q <= !out_tgl_q;
      end
      if (release_d) begin
        in_tgl_q <= !in_tgl_q;
      end
    end
  end

  // Turnaround timer restarts on every state change
  always_ff @(posedge clock) begin
    if (reset || state_d != state_q) begin
      timer_q <= '0;
    end else if (timing_w) begin
      timer_q <= timer_q + 1'b1;
    end
  end

  assign out_accept_o = state_q == RECV;
  assign in_send_o    = state_q == SEND;

  a_one_sender: assert property (@(posedge clock) disable iff (reset)
    !(hsk_send_o && data_send_o));

  a_one_ending: assert property (@(posedge clock) disable iff (reset)
    !(out_commit_o && out_discard_o));

endmodule

/* usb_out_buffer.sv */
`timescale 1ns/100ps
`include "usb_consts.svh"

module usb_out_buffer import usb_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  byte_t rx_tdata_i,
  input  logic  rx_tvalid_i,
  input  logic  out_accept_i,
  input  logic  out_commit_i,
  input  logic  out_discard_i,
  input  logic  out_tready_i,
  output logic  out_room_o,
  output byte_t out_tdata_o,
  output logic  out_tvalid_o
);

  localparam int DEPTH = `USB_OUT_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam logic [AW:0] FULL_LVL = (AW+1)'(DEPTH);
  localparam logic [AW:0] ROOM_LVL = (AW+1)'(DEPTH - `USB_MAX_PKT);

  byte_t mem_q [DEPTH];

  // Pointers carry one extra bit to tell full from empty
  logic [AW:0] wr_ptr_q;
  logic [AW:0] cmt_ptr_q;
  logic [AW:0] rd_ptr_q;
  logic [AW:0] used_w;
  logic wr_en_w, rd_en_w, full_w;

  // Uncommitted bytes count as used so a packet cannot overrun unread data
  assign used_w  = wr_ptr_q - rd_ptr_q;
  assign full_w  = used_w == FULL_LVL;
  assign wr_en_w = out_accept_i && rx_tvalid_i;
  assign rd_en_w = out_tvalid_o && out_tready_i;

  always_ff @(posedge clock) begin
    if (wr_en_w) begin
      mem_q[wr_ptr_q[AW-1:0]] <= rx_tdata_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q  <= '0;
      cmt_ptr_q <= '0;
    end else if (out_discard_i) begin
      // Drop everything written since the last good packet
      wr_ptr_q <= cmt_ptr_q;
    end else if (out_commit_i) begin
      cmt_ptr_q <= wr_ptr_q;
    end else if (wr_en_w) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr_q <= '0;
    end else if (rd_en_w) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // Room for one more maximum sized packet
  assign out_room_o = used_w <= ROOM_LVL;

  // The application only sees committed bytes
  assign out_tvalid_o = rd_ptr_q != cmt_ptr_q;
  assign out_tdata_o  = mem_q[rd_ptr_q[AW-1:0]];

  a_no_overrun: assert property (@(posedge clock) disable iff (reset)
    wr_en_w |-> !full_w);

endmodule

/* usb_in_buffer.sv */
`timescale 1ns/100ps
`include "usb_consts.svh"

module usb_in_buffer import usb_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  byte_t in_tdata_i,
  input  logic  in_tvalid_i,
  input  logic  in_tlast_i,
  input  logic  in_send_i,
  input  logic  in_release_i,
  input  logic  in_rewind_i,
  input  logic  tx_tready_i,
  output logic  in_tready_o,
  output logic  in_ready_o,
  output byte_t tx_tdata_o,
  output logic  tx_tvalid_o,
  output logic  tx_tlast_o
);

  localparam int DEPTH = `USB_IN_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam logic [AW:0] FULL_LVL = (AW+1)'(DEPTH);

  // Each entry holds the last flag above the data byte
  logic [8:0] mem_q [DEPTH];
  logic [8:0] entry_w;

  logic [AW:0] wr_ptr_q;
  logic [AW:0] start_ptr_q;
  logic [AW:0] rd_ptr_q;
  logic [AW:0] pkt_cnt_q;
  logic done_q;
  logic wr_en_w, rd_en_w, pkt_in_w;

  // Space is only given back once the host has acknowledged a packet
  assign in_tready_o = (wr_ptr_q - start_ptr_q) != FULL_LVL;
  assign wr_en_w     = in_tvalid_i && in_tready_o;
  assign pkt_in_w    = wr_en_w && in_tlast_i;

  always_ff @(posedge clock) begin
    if (wr_en_w) begin
      mem_q[wr_ptr_q[AW-1:0]] <= {in_tlast_i, in_tdata_i};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q <= '0;
    end else if (wr_en_w) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end
  end

  // Whole packets held, a new one and a release may land together
  always_ff @(posedge clock) begin
    if (reset) begin
      pkt_cnt_q <= '0;
    end else if (pkt_in_w && !in_release_i) begin
      pkt_cnt_q <= pkt_cnt_q + 1'b1;
    end else if (in_release_i && !pkt_in_w) begin
      pkt_cnt_q <= pkt_cnt_q - 1'b1;
    end
  end

  assign in_ready_o = pkt_cnt_q != '0;

  // Oldest packet streams out once and then waits for release or rewind
  assign entry_w     = mem_q[rd_ptr_q[AW-1:0]];
  assign tx_tdata_o  = entry_w[7:0];
  assign tx_tlast_o  = entry_w[8];
  assign tx_tvalid_o = in_send_i && in_ready_o && !done_q;
  assign rd_en_w     = tx_tvalid_o && tx_tready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      start_ptr_q <= '0;
      rd_ptr_q    <= '0;
      done_q      <= 1'b0;
    end else if (in_release_i) begin
      start_ptr_q <= rd_ptr_q;
      done_q      <= 1'b0;
    end else if (in_rewind_i) begin
      // Replay the same packet on the next IN token
      rd_ptr_q <= start_ptr_q;
      done_q   <= 1'b0;
    end else if (rd_en_w) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
      done_q   <= tx_tlast_o;
    end
  end

  a_release_held: assert property (@(posedge clock) disable iff (reset)
    in_release_i |-> pkt_cnt_q != '0);

endmodule

/* usb_bulk_func.sv */
`timescale 1ns/100ps

module usb_bulk_func import usb_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  usb_addr_t dev_addr_i,
  input  logic      set_conf_i,
  input  logic      clr_conf_i,
  // Packet decoder
  input  logic      tok_recv_i,
  input  pid_t      usb_pid_i,
  input  usb_addr_t tok_addr_i,
  input  endp_t     tok_endp_i,
  input  logic      usb_recv_i,
  input  byte_t     rx_tdata_i,
  input  logic      rx_tvalid_i,
  input  logic      eop_recv_i,
  input  logic      crc_error_i,
  input  logic      hsk_recv_i,
  // Packet encoder
  output logic      hsk_send_o,
  input  logic      hsk_sent_i,
  output logic      data_send_o,
  output pid_t      usb_pid_o,
  output byte_t     tx_tdata_o,
  output logic      tx_tvalid_o,
  input  logic      tx_tready_i,
  output logic      tx_tlast_o,
  input  logic      usb_sent_i,
  // Application
  output byte_t     out_tdata_o,
  output logic      out_tvalid_o,
  input  logic      out_tready_i,
  input  byte_t     in_tdata_i,
  input  logic      in_tvalid_i,
  input  logic      in_tlast_i,
  output logic      in_tready_o
);

  logic out_room, out_accept, out_commit, out_discard;
  logic in_ready, in_send, in_release, in_rewind;

  usb_transaction_ctrl usb_transaction_ctrl_i (
    .clock         (clock),
    .reset         (reset),
    .dev_addr_i    (dev_addr_i),
    .set_conf_i    (set_conf_i),
    .clr_conf_i    (clr_conf_i),
    .tok_recv_i    (tok_recv_i),
    .usb_pid_i     (usb_pid_i),
    .tok_addr_i    (tok_addr_i),
    .tok_endp_i    (tok_endp_i),
    .usb_recv_i    (usb_recv_i),
    .eop_recv_i    (eop_recv_i),
    .crc_error_i   (crc_error_i),
    .hsk_recv_i    (hsk_recv_i),
    .hsk_sent_i    (hsk_sent_i),
    .usb_sent_i    (usb_sent_i),
    .out_room_i    (out_room),
    .in_ready_i    (in_ready),
    .hsk_send_o    (hsk_send_o),
    .data_send_o   (data_send_o),
    .usb_pid_o     (usb_pid_o),
    .out_accept_o  (out_accept),
    .out_commit_o  (out_commit),
    .out_discard_o (out_discard),
    .in_send_o     (in_send),
    .in_release_o  (in_release),
    .in_rewind_o   (in_rewind)
  );

  // Decoder bytes in, application drains
  usb_out_buffer usb_out_buffer_i (
    .clock         (clock),
    .reset         (reset),
    .rx_tdata_i    (rx_tdata_i),
    .rx_tvalid_i   (rx_tvalid_i),
    .out_accept_i  (out_accept),
    .out_commit_i  (out_commit),
    .out_discard_i (out_discard),
    .out_tready_i  (out_tready_i),
    .out_room_o    (out_room),
    .out_tdata_o   (out_tdata_o),
    .out_tvalid_o  (out_tvalid_o)
  );

  // Application packets in, encoder drains
  usb_in_buffer usb_in_buffer_i (
    .clock        (clock),
    .reset        (reset),
    .in_tdata_i   (in_tdata_i),
    .in_tvalid_i  (in_tvalid_i),
    .in_tlast_i   (in_tlast_i),
    .in_send_i    (in_send),
    .in_release_i (in_release),
    .in_rewind_i  (in_rewind),
    .tx_tready_i  (tx_tready_i),
    .in_tready_o  (in_tready_o),
    .in_ready_o   (in_ready),
    .tx_tdata_o   (tx_tdata_o),
    .tx_tvalid_o  (tx_tvalid_o),
    .tx_tlast_o   (tx_tlast_o)
  );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clock_o,
  output logic reset_o
);

  // 8 ns period
  initial begin
    clock_o = 1'b0;
    forever begin
      #4 clock_o = ~clock_o;
    end
  end

  // Reset released on a falling edge after 16 cycles
  initial begin
    reset_o = 1'b1;
    repeat (16) @(posedge clock_o);
    @(negedge clock_o);
    reset_o = 1'b0;
  end

endmodule

/* tb_usb_bulk_func.sv */
`timescale 1ns/100ps
`include "usb_consts.svh"

module tb_usb_bulk_func import usb_pkg::*; ();

  localparam int N_XACT = 30;
  localparam int RSP_WAIT = `USB_TURNAROUND + 8;
  localparam usb_addr_t DEV_ADDR = 7'h2A;
  localparam usb_addr_t OTHER_ADDR = 7'h2B;
  localparam int PID_ACK = int'(`USBPID_ACK);
  localparam int PID_NAK = int'(`USBPID_NAK);
  localparam int PID_STALL = int'(`USBPID_STALL);
  localparam int PID_DATA0 = int'(`USBPID_DATA0);
  localparam int PID_DATA1 = int'(`USBPID_DATA1);
  localparam int K_OUT = 0;
  localparam int K_PING = 1;
  localparam int K_IN = 2;
  localparam int K_IN_ACK = 3;
  localparam int K_OTHER = 4;

  logic clock, reset;
  logic set_conf, clr_conf;
  logic tok_recv, usb_recv, eop_recv, crc_error, hsk_recv;
  pid_t usb_pid, out_pid;
  usb_addr_t tok_addr;
  endp_t tok_endp;
  byte_t rx_tdata, tx_tdata, out_tdata, in_tdata;
  logic rx_tvalid, hsk_send, hsk_sent, data_send, usb_sent;
  logic tx_tvalid, tx_tready, tx_tlast;
  logic out_tvalid, out_tready, in_tvalid, in_tlast, in_tready;

  // Model state
  string test_name = "reset";
  bit drain_en = 1'b0;
  bit conf_m = 1'b0;
  bit out_tgl_m = 1'b0;
  bit in_tgl_m = 1'b0;
  byte_t exp_out_q[$];
  byte_t exp_in_q[$];
  int exp_in_len[$];
  byte_t pkt_q[$];
  byte_t tx_q[$];

  tb_clock_gen tb_clock_gen_i (.clock_o(clock), .reset_o(reset));

  usb_bulk_func usb_bulk_func_i (
    .clock(clock), .reset(reset), .dev_addr_i(DEV_ADDR),
    .set_conf_i(set_conf), .clr_conf_i(clr_conf),
    .tok_recv_i(tok_recv), .usb_pid_i(usb_pid), .tok_addr_i(tok_addr),
    .tok_endp_i(tok_endp), .usb_recv_i(usb_recv), .rx_tdata_i(rx_tdata),
    .rx_tvalid_i(rx_tvalid), .eop_recv_i(eop_recv), .crc_error_i(crc_error),
    .hsk_recv_i(hsk_recv), .hsk_send_o(hsk_send), .hsk_sent_i(hsk_sent),
    .data_send_o(data_send), .usb_pid_o(out_pid), .tx_tdata_o(tx_tdata),
    .tx_tvalid_o(tx_tvalid), .tx_tready_i(tx_tready), .tx_tlast_o(tx_tlast),
    .usb_sent_i(usb_sent), .out_tdata_o(out_tdata), .out_tvalid_o(out_tvalid),
    .out_tready_i(out_tready), .in_tdata_i(in_tdata), .in_tvalid_i(in_tvalid),
    .in_tlast_i(in_tlast), .in_tready_o(in_tready)
  );

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    if (expected != actual) begin
      $display("FAILED %s (%s): expected %0d, actual %0d", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic report_error(input string reason);
    $display("ERROR in %s: %s", test_name, reason);
    abort_run();
  endtask

  // Expected handshake or DATAx PID or -1 when the device stays silent
  function automatic int predict_response(input int kind, input int dpid, input bit crc_bad);
    int rsp;
    int len;
    bit room;
    rsp = -1;
    room = exp_out_q.size() <= `USB_OUT_DEPTH - `USB_MAX_PKT;
    if (kind == K_PING) begin
      if (!conf_m) rsp = PID_STALL;
      else rsp = room ? PID_ACK : PID_NAK;
    end else if (kind == K_OUT) begin
      if (!conf_m) rsp = PID_STALL;
      else if (crc_bad) rsp = -1;
      else if ((dpid == PID_DATA1) != out_tgl_m) rsp = PID_ACK;
      else if (!room) rsp = PID_NAK;
      else begin
        foreach (pkt_q[i]) exp_out_q.push_back(pkt_q[i]);
        out_tgl_m = !out_tgl_m;
        rsp = PID_ACK;
      end
    end else if (kind == K_IN) begin
      if (!conf_m) rsp = PID_STALL;
      else if (exp_in_len.size() == 0) rsp = PID_NAK;
      else rsp = in_tgl_m ? PID_DATA1 : PID_DATA0;
    end else if (kind == K_IN_ACK) begin
      len = exp_in_len.pop_front();
      for (int i = 0; i < len; i++) begin
        void'(exp_in_q.pop_front());
      end
      in_tgl_m = !in_tgl_m;
    end
    return rsp;
  endfunction

  task automatic pause(input int n);
    repeat (n) @(negedge clock);
  endtask

  task automatic make_payload(input int len);
    pkt_q.delete();
    repeat (len) pkt_q.push_back(byte_t'($urandom));
  endtask

  task automatic send_token(input pid_t pid, input usb_addr_t addr, input endp_t endp);
    @(negedge clock);
    tok_recv = 1'b1;
    usb_pid = pid;
    tok_addr = addr;
    tok_endp = endp;
    @(negedge clock);
    tok_recv = 1'b0;
  endtask

  task automatic send_data(input pid_t pid, input bit crc_bad);
    @(negedge clock);
    usb_recv = 1'b1;
    usb_pid = pid;
    foreach (pkt_q[i]) begin
      @(negedge clock);
      usb_recv = 1'b0;
      rx_tvalid = 1'b1;
      rx_tdata = pkt_q[i];
    end
    @(negedge clock);
    rx_tvalid = 1'b0;
    eop_recv = !crc_bad;
    crc_error = crc_bad;
    @(negedge clock);
    eop_recv = 1'b0;
    crc_error = 1'b0;
  endtask

  // Encoder side pulls bytes with random gaps
  task automatic stream_tx();
    bit done;
    done = 1'b0;
    tx_q.delete();
    while (!done) begin
      @(negedge clock);
      tx_tready = $urandom_range(2) != 0;
      if (tx_tvalid && tx_tready) begin
        tx_q.push_back(tx_tdata);
        done = tx_tlast;
      end
    end
    @(negedge clock);
    tx_tready = 1'b0;
    usb_sent = 1'b1;
    @(negedge clock);
    usb_sent = 1'b0;
  endtask

  task automatic get_response(output int pid, output int lat);
    pid = -1;
    lat = 0;
    while (!hsk_send && !data_send && lat < RSP_WAIT) begin
      @(negedge clock);
      lat++;
    end
    if (hsk_send) begin
      pid = int'(out_pid);
      repeat ($urandom_range(3)) @(negedge clock);
      hsk_sent = 1'b1;
      @(negedge clock);
      hsk_sent = 1'b0;
    end else if (data_send) begin
      pid = int'(out_pid);
      stream_tx();
    end
  endtask

  task automatic expect_response(input int expected);
    int pid;
    int lat;
    get_response(pid, lat);
    check_value("response PID", expected, pid);
    if (expected != -1) check_value("response latency", 0, lat);
  endtask

  task automatic run_out(input pid_t dpid, input int len, input bit crc_bad);
    int exp;
    make_payload(len);
    send_token(`USBPID_OUT, DEV_ADDR, `USB_EP_OUT);
    if (conf_m) send_data(dpid, crc_bad);
    exp = predict_response(K_OUT, int'(dpid), crc_bad);
    expect_response(exp);
    pause(3);
  endtask

  task automatic run_ping();
    send_token(`USBPID_PING, DEV_ADDR, `USB_EP_OUT);
    expect_response(predict_response(K_PING, 0, 1'b0));
    pause(3);
  endtask

  task automatic run_foreign();
    send_token(`USBPID_IN, OTHER_ADDR, `USB_EP_IN);
    expect_response(predict_response(K_OTHER, 0, 1'b0));
    pause(3);
  endtask

  task automatic run_in(input bit ack);
    int exp;
    int pid;
    int lat;
    send_token(`USBPID_IN, DEV_ADDR, `USB_EP_IN);
    exp = predict_response(K_IN, 0, 1'b0);
    get_response(pid, lat);
    check_value("response PID", exp, pid);
    check_value("response latency", 0, lat);
    if (exp == PID_DATA0 || exp == PID_DATA1) begin
      check_value("IN packet length", exp_in_len[0], tx_q.size());
      foreach (tx_q[i]) check_value("IN byte", int'(exp_in_q[i]), int'(tx_q[i]));
      if (ack) begin
        pause(2);
        hsk_recv = 1'b1;
        @(negedge clock);
        hsk_recv = 1'b0;
        void'(predict_response(K_IN_ACK, 0, 1'b0));
      end else begin
        // Let the turnaround timer expire so the packet is rewound
        pause(`USB_TURNAROUND + 10);
      end
    end
    pause(3);
  endtask

  task automatic write_in_packet(input int len);
    int i;
    make_payload(len);
    i = 0;
    while (i < len) begin
      @(negedge clock);
      in_tvalid = 1'b1;
      in_tdata = pkt_q[i];
      in_tlast = i == len - 1;
      // Space comes back only when the host acknowledges a packet
      check_value("IN ready", int'(exp_in_q.size() + i < `USB_IN_DEPTH), int'(in_tready));
      if (in_tready) i++;
    end
    @(negedge clock);
    in_tvalid = 1'b0;
    in_tlast = 1'b0;
    foreach (pkt_q[j]) exp_in_q.push_back(pkt_q[j]);
    exp_in_len.push_back(len);
    pause(2);
  endtask

  task automatic wait_drained();
    while (exp_out_q.size() != 0) @(negedge clock);
    pause(2);
  endtask

  // Application side of the OUT buffer compares every drained byte
  initial begin : out_drain
    out_tready = 1'b0;
    forever begin
      @(negedge clock);
      out_tready = drain_en && $urandom_range(3) != 0;
      if (out_tvalid && out_tready) begin
        if (exp_out_q.size() == 0) report_error("a byte reached the application unexpectedly");
        else check_value("OUT byte", int'(exp_out_q.pop_front()), int'(out_tdata));
      end
    end
  end

  initial begin : watchdog
    repeat (N_XACT * 400) @(posedge clock);
    report_error("watchdog expired before the tests finished");
  end

  initial begin : main
    void'($urandom(49));
    set_conf = 1'b0;
    clr_conf = 1'b0;
    tok_recv = 1'b0;
    usb_pid = '0;
    tok_addr = '0;
    tok_endp = '0;
    usb_recv = 1'b0;
    rx_tdata = '0;
    rx_tvalid = 1'b0;
    eop_recv = 1'b0;
    crc_error = 1'b0;
    hsk_recv = 1'b0;
    hsk_sent = 1'b0;
    tx_tready = 1'b0;
    usb_sent = 1'b0;
    in_tdata = '0;
    in_tvalid = 1'b0;
    in_tlast = 1'b0;
    @(negedge reset);
    pause(2);

    test_name = "unconfigured";
    run_out(`USBPID_DATA0, 8, 1'b0);
    run_in(1'b1);
    run_ping();
    run_foreign();
    @(negedge clock);
    set_conf = 1'b1;
    @(negedge clock);
    set_conf = 1'b0;
    conf_m = 1'b1;
    out_tgl_m = 1'b0;
    in_tgl_m = 1'b0;
    pause(3);
    run_foreign();

    test_name = "out_toggle";
    drain_en = 1'b1;
    repeat (6) begin
      wait_drained();
      run_out(out_tgl_m ? `USBPID_DATA1 : `USBPID_DATA0, $urandom_range(64, 1), 1'b0);
    end
    // Repeated toggle is acknowledged but dropped
    run_out(out_tgl_m ? `USBPID_DATA0 : `USBPID_DATA1, 16, 1'b0);
    wait_drained();

    test_name = "out_flow";
    run_out(out_tgl_m ? `USBPID_DATA1 : `USBPID_DATA0, 20, 1'b1);
    wait_drained();
    drain_en = 1'b0;
    repeat (3) begin
      run_out(out_tgl_m ? `USBPID_DATA1 : `USBPID_DATA0, `USB_MAX_PKT, 1'b0);
    end
    run_ping();
    drain_en = 1'b1;
    wait_drained();
    run_ping();

    test_name = "in_data";
    run_in(1'b1);
    repeat (3) write_in_packet($urandom_range(40, 1));
    repeat (3) run_in(1'b1);

    test_name = "in_replay";
    repeat (2) write_in_packet($urandom_range(40, 1));
    run_in(1'b0);
    run_in(1'b1);
    run_in(1'b1);
    run_in(1'b1);

    pause(10);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
usb_pkg.sv
usb_transaction_ctrl.sv
usb_out_buffer.sv
usb_in_buffer.sv
usb_bulk_func.sv
tb_clock_gen.sv
tb_usb_bulk_func.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f vlog.f --top-module tb_usb_bulk_func -Mdir obj_dir
	./obj_dir/Vtb_usb_bulk_func 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
